//--- common/bank_if.sv
// ------------------------------
// Bank interface between sequencer,
// storage banks and MAC
// ------------------------------
`timescale 1ns/1ps
`include "cad_defines.svh"

interface bank_if
  import cad_pkg::*;
();

  // Per-bank image address and write strobes
  bank_addr_t                 img_addr [`CAD_NUM_BANKS];
  logic [`CAD_NUM_BANKS-1:0]  img_we;
  logic [`CAD_NUM_BANKS-1:0]  ker_we;

  // Every bank reads the same kernel row
  ker_addr_t                  ker_addr;
  pix_t                       wdata;

  // Registered read data, one entry per bank
  pix_t                       pix [`CAD_NUM_BANKS];
  pix_t                       wgt [`CAD_NUM_BANKS];

  modport seq (
    output img_addr, img_we, ker_addr, ker_we, wdata
  );

  modport bank (
    input  img_addr, img_we, ker_addr, ker_we, wdata,
    output pix, wgt
  );

  modport mac (
    input pix, wgt
  );

endinterface

//--- common/cad_defines.svh
// ------------------------------
// Image, kernel, bank and word sizes
// ------------------------------
`ifndef CAD_DEFINES_SVH
`define CAD_DEFINES_SVH

// Image and kernel geometry
`define CAD_IMG_DIM    8
`define CAD_KER_DIM    5

// One bank per kernel column
`define CAD_NUM_BANKS  5

// Data widths
`define CAD_PIX_W      8
`define CAD_ACC_W      20

// Bank storage, two column groups of eight rows
`define CAD_BANK_DEPTH 16
`define CAD_BANK_AW    4

// Pooled words per run
`define CAD_OUT_WORDS  4

`endif

//--- common/cad_pkg.sv
// ------------------------------
// Shared data and address types
// ------------------------------
`include "cad_defines.svh"

package cad_pkg;

  // Pixel or kernel weight
  typedef logic signed [`CAD_PIX_W-1:0] pix_t;

  // Accumulator and pooled result
  typedef logic signed [`CAD_ACC_W-1:0] acc_t;

  // Image address inside one bank
  typedef logic [`CAD_BANK_AW-1:0] bank_addr_t;

  // Kernel row
  typedef logic [2:0] ker_addr_t;

  // Lane rotation for weight alignment
  typedef logic [2:0] rot_t;

endpackage

//--- common/conv_tag_if.sv
// ------------------------------
// Per-cycle compute tags
// ------------------------------
`timescale 1ns/1ps

interface conv_tag_if
  import cad_pkg::*;
();

  logic valid;
  rot_t rot;
  // Last kernel row of one conv output
  logic conv_last;
  // Last conv output of one pooling window
  logic pool_last;

  modport seq (output valid, rot, conv_last, pool_last);
  modport mac (input  valid, rot, conv_last, pool_last);

endinterface

//--- compile.f
+incdir+common
common/cad_pkg.sv
common/bank_if.sv
common/conv_tag_if.sv
conv_sequencer/conv_sequencer.sv
verilog/img_bank.sv
mac_pool/mac_pool.sv
verilog/out_serializer.sv
verilog/cad_top.sv
verif/cad_tb.sv

//--- conv_sequencer/conv_sequencer.sv
// ------------------------------
// Load and compute control with
// bank address generation
// ------------------------------
`timescale 1ns/1ps
`include "cad_defines.svh"

module conv_sequencer
  import cad_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  input  logic    in_valid,
  input  logic    in_valid2,
  input  pix_t    matrix,
  bank_if.seq     banks,
  conv_tag_if.seq tags
);

  localparam int IMG_PIX  = `CAD_IMG_DIM * `CAD_IMG_DIM;
  localparam int LOAD_LEN = IMG_PIX + `CAD_KER_DIM * `CAD_KER_DIM;
  localparam int KER_LAST = `CAD_KER_DIM - 1;
  localparam int WIN_LAST = `CAD_OUT_WORDS * 4 - 1;

  typedef enum logic [1:0] {S_IDLE, S_LOAD, S_COMP} state_t;

  state_t    state;
  logic [6:0] ld_cnt;
  logic [2:0] kx_cnt;
  ker_addr_t  ky_ld;
  ker_addr_t  ky;
  // {py, px, dy, dx}
  logic [3:0] win_cnt;

  logic       wr;
  logic       ld_ker;
  logic [2:0] ld_x;
  logic [2:0] ld_y;
  logic       ld_hi;
  logic [2:0] ld_bank;
  logic [1:0] ox;
  logic [1:0] oy;
  logic [2:0] row;
  logic       conv_last;

  // ------------------------------
  // Load addressing
  // ------------------------------
  assign wr      = in_valid && (state != S_COMP);
  assign ld_ker  = (ld_cnt >= 7'(IMG_PIX));
  assign ld_x    = ld_cnt[2:0];
  assign ld_y    = ld_cnt[5:3];
  assign ld_hi   = (ld_x >= 3'd5);
  assign ld_bank = ld_hi ? ld_x - 3'd5 : ld_x;

  // ------------------------------
  // Compute position
  // ------------------------------
  assign ox        = {win_cnt[2], win_cnt[0]};
  assign oy        = {win_cnt[3], win_cnt[1]};
  assign row       = {1'b0, oy} + ky;
  assign conv_last = (ky == ker_addr_t'(KER_LAST));

  always_comb
  begin
    banks.wdata    = matrix;
    banks.ker_addr = (state == S_COMP) ? ky : ky_ld;
    for (int b = 0; b < `CAD_NUM_BANKS; b++)
    begin
      banks.img_we[b] = wr && !ld_ker && (ld_bank == 3'(b));
      banks.ker_we[b] = wr && ld_ker && (kx_cnt == 3'(b));
      // Bank b serves column ox + ((b - ox) mod 5), in the upper group when b < ox
      if (state == S_COMP)
        banks.img_addr[b] = {(3'(b) < {1'b0, ox}), row};
      else
        banks.img_addr[b] = {ld_hi, ld_y};
    end
  end

  // Tags travel with the addresses; ox < 5 so it is its own rotation
  assign tags.valid     = (state == S_COMP);
  assign tags.rot       = rot_t'(ox);
  assign tags.conv_last = conv_last;
  assign tags.pool_last = conv_last && win_cnt[0] && win_cnt[1];

  // ------------------------------
  // Control FSM
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state   <= S_IDLE;
      ld_cnt  <= '0;
      kx_cnt  <= '0;
      ky_ld   <= '0;
      ky      <= '0;
      win_cnt <= '0;
    end
    else
    begin
      case (state)
        S_IDLE:
        begin
          // First pixel is written in this cycle already
          if (in_valid)
          begin
            state  <= S_LOAD;
            ld_cnt <= 7'd1;
          end
          else if (in_valid2)
          begin
            state   <= S_COMP;
            ky      <= '0;
            win_cnt <= '0;
          end
        end
        S_LOAD:
        begin
          if (ld_ker)
          begin
            if (kx_cnt == 3'(KER_LAST))
            begin
              kx_cnt <= '0;
              ky_ld  <= ky_ld + 1'b1;
            end
            else
              kx_cnt <= kx_cnt + 1'b1;
          end
          if (!in_valid || ld_cnt == 7'(LOAD_LEN - 1))
          begin
            state  <= S_IDLE;
            ld_cnt <= '0;
            kx_cnt <= '0;
            ky_ld  <= '0;
          end
          else
            ld_cnt <= ld_cnt + 1'b1;
        end
        S_COMP:
        begin
          if (conv_last)
          begin
            ky      <= '0;
            win_cnt <= win_cnt + 1'b1;
            if (win_cnt == 4'(WIN_LAST))
              state <= S_IDLE;
          end
          else
            ky <= ky + 1'b1;
        end
        default:
          state <= S_IDLE;
      endcase
    end
  end

endmodule

//--- mac_pool/mac_pool.sv
// ------------------------------
// Five-lane MAC, row accumulation
// and 2x2 max pooling
// ------------------------------
`timescale 1ns/1ps
`include "cad_defines.svh"

module mac_pool
  import cad_pkg::*;
(
  input  logic    clk,
  input  logic    rst_n,
  bank_if.mac     banks,
  conv_tag_if.mac tags,
  output acc_t    result,
  output logic    result_valid
);

  localparam int NB = `CAD_NUM_BANKS;

  // Tags delayed to meet the bank read data
  logic v_q;
  rot_t rot_q;
  logic conv_last_q;
  logic pool_last_q;

  acc_t row_sum;
  acc_t conv_sum;
  acc_t conv_acc;
  acc_t max_next;
  acc_t max_q;
  logic win_first;

  // Pixel lane b meets the weight of kernel column (b - rot) mod 5
  always_comb
  begin
    int widx;
    row_sum = '0;
    for (int b = 0; b < NB; b++)
    begin
      widx = b + NB - int'(rot_q);
      if (widx >= NB)
        widx = widx - NB;
      row_sum = row_sum + banks.pix[b] * banks.wgt[widx];
    end
  end

  assign conv_sum = conv_acc + row_sum;
  assign max_next = (win_first || conv_sum > max_q) ? conv_sum : max_q;

  // ------------------------------
  // Control and accumulation
  // ------------------------------
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      v_q          <= 1'b0;
      rot_q        <= '0;
      conv_last_q  <= 1'b0;
      pool_last_q  <= 1'b0;
      conv_acc     <= '0;
      win_first    <= 1'b1;
      result_valid <= 1'b0;
    end
    else
    begin
      v_q          <= tags.valid;
      rot_q        <= tags.rot;
      conv_last_q  <= tags.valid && tags.conv_last;
      pool_last_q  <= tags.valid && tags.pool_last;
      result_valid <= pool_last_q;
      // Restart on the row after the last kernel row
      if (v_q)
        conv_acc <= conv_last_q ? '0 : conv_sum;
      if (conv_last_q)
        win_first <= pool_last_q;
    end
  end

  // Running max and window result
  always_ff @(posedge clk)
  begin
    if (conv_last_q)
      max_q <= max_next;
    if (pool_last_q)
      result <= max_next;
  end

endmodule

//--- verif/cad_tb.sv
// ------------------------------
// Testbench for the CNN feature engine
// ------------------------------
`timescale 1ns/1ps
`include "cad_defines.svh"

module cad_tb;

  localparam int NUM_RUNS   = 5;
  localparam int RUN_CYCLES = 300;
  localparam int RUN_BITS   = `CAD_OUT_WORDS * `CAD_ACC_W;
  localparam int LOAD_LEN   = `CAD_IMG_DIM * `CAD_IMG_DIM + `CAD_KER_DIM * `CAD_KER_DIM;

  logic                  clk;
  logic                  rst_n;
  logic                  in_valid;
  logic                  in_valid2;
  logic [`CAD_PIX_W-1:0] matrix;
  logic                  out_valid;
  logic                  out_value;

  // Reference data and results
  logic signed [`CAD_PIX_W-1:0] img [`CAD_IMG_DIM][`CAD_IMG_DIM];
  logic signed [`CAD_PIX_W-1:0] ker [`CAD_KER_DIM][`CAD_KER_DIM];
  logic [`CAD_ACC_W-1:0]        exp_words [`CAD_OUT_WORDS];
  logic [`CAD_ACC_W-1:0]        got_words [`CAD_OUT_WORDS];
  logic [`CAD_ACC_W-1:0]        cur_word;
  logic [31:0]                  lfsr;
  int                           bits_left;
  int                           bit_idx;
  int                           words_got;

  cad_top UUT (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_valid2 (in_valid2),
    .matrix    (matrix),
    .out_valid (out_valid),
    .out_value (out_value)
  );

  always #20 clk = ~clk;

  // ------------------------------
  // Helpers
  // ------------------------------
  task automatic fail_stop(input string what);
    $display("Errors found");
    $fatal(1, "%s", what);
  endtask

  // Taps 32, 22, 2, 1
  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    lfsr_next = {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
  endfunction

  task automatic rand_byte(output logic [7:0] v);
    v = '0;
    for (int i = 0; i < 8; i++)
    begin
      lfsr = lfsr_next(lfsr);
      v    = {v[6:0], lfsr[0]};
    end
  endtask

  task automatic fill_random;
    for (int y = 0; y < `CAD_IMG_DIM; y++)
      for (int x = 0; x < `CAD_IMG_DIM; x++)
        rand_byte(img[y][x]);
    for (int ky = 0; ky < `CAD_KER_DIM; ky++)
      for (int kx = 0; kx < `CAD_KER_DIM; kx++)
        rand_byte(ker[ky][kx]);
  endtask

  // Every product is 127 * -128
  task automatic fill_extreme;
    for (int y = 0; y < `CAD_IMG_DIM; y++)
      for (int x = 0; x < `CAD_IMG_DIM; x++)
        img[y][x] = 8'sd127;
    for (int ky = 0; ky < `CAD_KER_DIM; ky++)
      for (int kx = 0; kx < `CAD_KER_DIM; kx++)
        ker[ky][kx] = -8'sd128;
  endtask

  // Single unit weight makes conv(ox, oy) equal img[oy][ox]
  task automatic fill_windows;
    for (int y = 0; y < `CAD_IMG_DIM; y++)
      for (int x = 0; x < `CAD_IMG_DIM; x++)
        img[y][x] = 8'(-40 - 8 * y - x);
    for (int ky = 0; ky < `CAD_KER_DIM; ky++)
      for (int kx = 0; kx < `CAD_KER_DIM; kx++)
        ker[ky][kx] = '0;
    ker[0][0] = 8'sd1;
    // All negative window with its max at (1,1)
    img[1][1] = -8'sd3;
    img[0][3] = 8'sd90;
    img[3][0] = 8'sd17;
    img[2][2] = 8'sd127;
    img[3][3] = -8'sd128;
  endtask

  task automatic compute_expected;
    int conv [4][4];
    int s;
    int best;
    for (int oy = 0; oy < 4; oy++)
      for (int ox = 0; ox < 4; ox++)
      begin
        s = 0;
        for (int ky = 0; ky < `CAD_KER_DIM; ky++)
          for (int kx = 0; kx < `CAD_KER_DIM; kx++)
            s += int'(img[oy + ky][ox + kx]) * int'(ker[ky][kx]);
        conv[oy][ox] = s;
      end
    // Window order (0,0), (1,0), (0,1), (1,1)
    for (int w = 0; w < `CAD_OUT_WORDS; w++)
    begin
      best = conv[2 * (w / 2)][2 * (w % 2)];
      for (int dy = 0; dy < 2; dy++)
        for (int dx = 0; dx < 2; dx++)
          if (conv[2 * (w / 2) + dy][2 * (w % 2) + dx] > best)
            best = conv[2 * (w / 2) + dy][2 * (w % 2) + dx];
      exp_words[w] = best[`CAD_ACC_W-1:0];
    end
  endtask

  // ------------------------------
  // Stimulus
  // ------------------------------
  task automatic load_matrices;
    for (int n = 0; n < LOAD_LEN; n++)
    begin
      @(negedge clk);
      in_valid = 1'b1;
      if (n < 64)
        matrix = img[n / 8][n % 8];
      else
        matrix = ker[(n - 64) / 5][(n - 64) % 5];
    end
    @(negedge clk);
    in_valid = 1'b0;
    matrix   = '0;
  endtask

  task automatic run_and_check;
    @(negedge clk);
    bits_left = RUN_BITS;
    bit_idx   = 0;
    words_got = 0;
    in_valid2 = 1'b1;
    @(negedge clk);
    in_valid2 = 1'b0;
    wait (words_got == `CAD_OUT_WORDS);
    // Collector flags any extra bit in this quiet period
    repeat (40) @(negedge clk);
    for (int w = 0; w < `CAD_OUT_WORDS; w++)
    begin
      assert (got_words[w] === exp_words[w])
      else
      begin
        $display("[ERROR] %0t out_value word %0d expected %h got %h",
                 $time, w, exp_words[w], got_words[w]);
        fail_stop("pooled result mismatch");
      end
    end
  endtask

  // Output collector for MSB-first words
  always @(negedge clk)
  begin
    if (out_valid === 1'b1)
    begin
      assert (bits_left > 0)
      else
      begin
        $display("[ERROR] %0t out_valid expected 0 got 1", $time);
        fail_stop("out_valid high with no run pending");
      end
      bits_left = bits_left - 1;
      cur_word  = {cur_word[`CAD_ACC_W-2:0], out_value};
      bit_idx   = bit_idx + 1;
      if (bit_idx == `CAD_ACC_W)
      begin
        got_words[words_got] = cur_word;
        words_got = words_got + 1;
        bit_idx   = 0;
      end
    end
  end

  // Watchdog
  initial
  begin
    repeat (NUM_RUNS * RUN_CYCLES + 40) @(posedge clk);
    $display("Timeout: the run did not finish in time");
    fail_stop("watchdog expired");
  end

  initial
  begin
    clk       = 1'b0;
    rst_n     = 1'b0;
    in_valid  = 1'b0;
    in_valid2 = 1'b0;
    matrix    = '0;
    lfsr      = 32'd84322;
    cur_word  = '0;
    bits_left = 0;
    bit_idx   = 0;
    words_got = 0;
    repeat (10) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;

    // Outputs quiet before any stimulus
    repeat (20)
    begin
      @(negedge clk);
      assert (out_valid === 1'b0 && out_value === 1'b0)
      else
      begin
        $display("[ERROR] %0t out_valid/out_value expected 0/0 got %b/%b",
                 $time, out_valid, out_value);
        fail_stop("outputs active after reset");
      end
    end

    fill_random();
    load_matrices();
    compute_expected();
    run_and_check();
    // Same stored data again
    run_and_check();

    fill_random();
    load_matrices();
    compute_expected();
    run_and_check();

    fill_extreme();
    load_matrices();
    compute_expected();
    run_and_check();

    fill_windows();
    load_matrices();
    compute_expected();
    run_and_check();

    $display("No errors");
    $finish;
  end

endmodule

//--- verilog/cad_top.sv
// ------------------------------
// CNN feature engine top level
// ------------------------------
`timescale 1ns/1ps
`include "cad_defines.svh"

module cad_top
  import cad_pkg::*;
(
  input  logic                  clk,
  input  logic                  rst_n,
  input  logic                  in_valid,
  input  logic                  in_valid2,
  input  logic [`CAD_PIX_W-1:0] matrix,
  output logic                  out_valid,
  output logic                  out_value
);

  acc_t result;
  logic result_valid;

  bank_if     banks ();
  conv_tag_if tags ();

  conv_sequencer u_seq (
    .clk       (clk),
    .rst_n     (rst_n),
    .in_valid  (in_valid),
    .in_valid2 (in_valid2),
    .matrix    (pix_t'(matrix)),
    .banks     (banks.seq),
    .tags      (tags.seq)
  );

  // Column x lives in bank x mod 5
  for (genvar b = 0; b < `CAD_NUM_BANKS; b++) begin : g_bank
    img_bank #(
      .BANK_IDX (b)
    ) u_bank (
      .clk   (clk),
      .rst_n (rst_n),
      .port  (banks.bank)
    );
  end

  mac_pool u_mac (
    .clk          (clk),
    .rst_n        (rst_n),
    .banks        (banks.mac),
    .tags         (tags.mac),
    .result       (result),
    .result_valid (result_valid)
  );

  out_serializer u_ser (
    .clk          (clk),
    .rst_n        (rst_n),
    .result       (result),
    .result_valid (result_valid),
    .out_valid    (out_valid),
    .out_value    (out_value)
  );

endmodule

//--- verilog/img_bank.sv
// ------------------------------
// One image/kernel storage bank
// ------------------------------
`timescale 1ns/1ps
`include "cad_defines.svh"

module img_bank
  import cad_pkg::*;
#(
  parameter int BANK_IDX = 0
)
(
  input  logic clk,
  input  logic rst_n,
  bank_if.bank port
);

  pix_t img_mem [`CAD_BANK_DEPTH];
  // One kernel column, indexed by row
  pix_t ker_mem [`CAD_KER_DIM];
  pix_t pix_q;
  pix_t wgt_q;

  always_ff @(posedge clk)
  begin
    if (port.img_we[BANK_IDX])
      img_mem[port.img_addr[BANK_IDX]] <= port.wdata;
    if (port.ker_we[BANK_IDX])
      ker_mem[port.ker_addr] <= port.wdata;
  end

  // Synchronous read, data one cycle after address
  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      pix_q <= '0;
      wgt_q <= '0;
    end
    else
    begin
      pix_q <= img_mem[port.img_addr[BANK_IDX]];
      wgt_q <= ker_mem[port.ker_addr];
    end
  end

  assign port.pix[BANK_IDX] = pix_q;
  assign port.wgt[BANK_IDX] = wgt_q;

endmodule

//--- verilog/out_serializer.sv
// ------------------------------
// Result buffer and MSB-first
// bit serializer
// ------------------------------
`timescale 1ns/1ps
`include "cad_defines.svh"

module out_serializer
  import cad_pkg::*;
(
  input  logic clk,
  input  logic rst_n,
  input  acc_t result,
  input  logic result_valid,
  output logic out_valid,
  output logic out_value
);

  localparam int LAST_BIT = `CAD_ACC_W - 1;
  localparam int CNT_W    = $clog2(`CAD_ACC_W);

  acc_t             buf_word;
  logic             buf_full;
  acc_t             shift_q;
  logic [CNT_W-1:0] bit_cnt;

  logic word_done;
  logic take_buf;
  logic take_new;
  logic to_buf;
  acc_t next_word;

  // Idle, or the last bit of a word is on the output
  assign word_done = !out_valid || (bit_cnt == CNT_W'(LAST_BIT));
  // Buffered word is older, so it goes first
  assign take_buf  = word_done && buf_full;
  assign take_new  = word_done && !buf_full && result_valid;
  assign to_buf    = result_valid && !take_new;
  assign next_word = take_buf ? buf_word : result;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      out_valid <= 1'b0;
      out_value <= 1'b0;
      buf_full  <= 1'b0;
      bit_cnt   <= '0;
    end
    else
    begin
      if (word_done)
      begin
        if (take_buf || take_new)
        begin
          out_valid <= 1'b1;
          out_value <= next_word[LAST_BIT];
          bit_cnt   <= '0;
        end
        else
        begin
          out_valid <= 1'b0;
          out_value <= 1'b0;
        end
      end
      else
      begin
        out_value <= shift_q[LAST_BIT];
        bit_cnt   <= bit_cnt + 1'b1;
      end
      if (to_buf)
        buf_full <= 1'b1;
      else if (take_buf)
        buf_full <= 1'b0;
    end
  end

  // Remaining bits, next one at the top
  always_ff @(posedge clk)
  begin
    if (take_buf || take_new)
      shift_q <= next_word << 1;
    else if (!word_done)
      shift_q <= shift_q << 1;
    if (to_buf)
      buf_word <= result;
  end

endmodule
